/* i2c_bus_pkg.sv */
`default_nettype none

package i2c_bus_pkg;

    // ----------------------------------------------------------
    // bit timing
    // ----------------------------------------------------------
    localparam int QTR_PER_BIT   = 4;                    // dri_clk cycles per scl bit
    localparam int QTR_W         = $clog2(QTR_PER_BIT);
    localparam int BITS_PER_BYTE = 8;                    // data bits, ack slot follows
    localparam int BIT_W         = $clog2(BITS_PER_BYTE);

    // quarter names inside one scl bit
    typedef enum logic [QTR_W-1:0] {
        Q_SETUP  = 2'd0,                                 // sda moves, scl low
        Q_RISE   = 2'd1,                                 // scl goes high
        Q_SAMPLE = 2'd2,                                 // sda read at end of this quarter
        Q_FALL   = 2'd3                                  // scl back low
    } qtr_t;

    // segments of one byte job on the bus
    typedef enum logic [2:0] {
        SEG_IDLE,
        SEG_START,                                       // start or repeated start
        SEG_BITS,                                        // eight data bits, msb first
        SEG_ACK,                                         // acknowledge slot
        SEG_STOP
    } seg_t;

    // ----------------------------------------------------------
    // byte jobs between sequencer and engine
    // ----------------------------------------------------------
    typedef struct packed {
        logic       start;                               // start before the byte
        logic       stop;                                // stop after the ack slot
        logic       rd;                                  // receive, answer with nack
        logic [7:0] data;                                // byte to send
    } byte_job_t;

    typedef struct packed {
        logic       nack;                                // ack slot seen high
        logic [7:0] data;                                // received byte
    } byte_res_t;

endpackage

`default_nettype wire

/* i2c_xact_pkg.sv */
`default_nettype none

package i2c_xact_pkg;

    localparam logic [6:0] SLAVE_ADDR = 7'h52;           // eeprom device address
    localparam logic       DIR_WR     = 1'b0;            // r/w bit after the address
    localparam logic       DIR_RD     = 1'b1;

    // ----------------------------------------------------------
    // user side command and response
    // ----------------------------------------------------------
    typedef struct packed {
        logic        rd;                                 // read when set
        logic        addr16;                             // two word address bytes
        logic [15:0] addr;
        logic [7:0]  wdata;
    } i2c_cmd_t;

    typedef struct packed {
        logic       nack;                                // any ack slot seen high
        logic [7:0] rdata;                               // zero for writes
    } i2c_rsp_t;

    // sequencer phases, one per byte job plus idle and respond
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_DEV,                                          // device address, write
        PH_ADDR_HI,
        PH_ADDR_LO,
        PH_WDATA,
        PH_RE_ADDR,                                      // repeated start, read
        PH_RDATA,
        PH_RESP
    } seq_phase_t;

endpackage

`default_nettype wire

/* i2c_hold_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_hold_stage #(
    parameter type payload_t = logic
) (
    input  logic     dri_clk,
    input  logic     rst_n,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     full;
    payload_t data_q;

    // takes a new entry in the cycle the old one leaves
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;                            // refill or drain
        end
    end

    always_ff @(posedge dri_clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

/* i2c_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_sequencer
    import i2c_bus_pkg::*, i2c_xact_pkg::*;
(
    input  logic      dri_clk,
    input  logic      rst_n,

    input  logic      cmd_valid,
    input  i2c_cmd_t  cmd,
    output logic      cmd_ready,

    output logic      job_valid,
    output byte_job_t job,
    input  logic      job_ready,

    input  logic      res_valid,
    input  byte_res_t res,

    output logic      rsp_valid,
    output i2c_rsp_t  rsp,
    input  logic      rsp_ready
);

    seq_phase_t phase;
    seq_phase_t phase_nx;
    i2c_cmd_t   cmd_q;
    logic       nack_acc;
    logic [7:0] rdata_q;

    assign cmd_ready = (phase == PH_IDLE);
    assign rsp_valid = (phase == PH_RESP);
    assign rsp       = '{nack: nack_acc, rdata: rdata_q};

    // phase after the current byte job has finished
    always_comb begin
        case (phase)
            PH_DEV:     phase_nx = cmd_q.addr16 ? PH_ADDR_HI : PH_ADDR_LO;
            PH_ADDR_HI: phase_nx = PH_ADDR_LO;
            PH_ADDR_LO: phase_nx = cmd_q.rd ? PH_RE_ADDR : PH_WDATA;
            PH_RE_ADDR: phase_nx = PH_RDATA;
            default:    phase_nx = PH_RESP;              // last job of either kind
        endcase
    end

    // ----------------------------------------------------------
    // byte job for each phase
    // ----------------------------------------------------------
    always_comb begin
        job = '0;
        case (phase)
            PH_DEV: begin
                job.start = 1'b1;
                job.data  = {SLAVE_ADDR, DIR_WR};
            end
            PH_ADDR_HI: job.data = cmd_q.addr[15:8];
            PH_ADDR_LO: job.data = cmd_q.addr[7:0];
            PH_WDATA: begin
                job.stop = 1'b1;
                job.data = cmd_q.wdata;
            end
            PH_RE_ADDR: begin
                job.start = 1'b1;                        // repeated start
                job.data  = {SLAVE_ADDR, DIR_RD};
            end
            PH_RDATA: begin
                job.rd   = 1'b1;
                job.stop = 1'b1;
                job.data = 8'hff;                        // sda released
            end
            default: ;
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            job_valid <= 1'b0;
        end else begin
            if (job_valid && job_ready) begin
                job_valid <= 1'b0;
            end
            case (phase)
                PH_IDLE: begin
                    if (cmd_valid) begin
                        phase     <= PH_DEV;
                        job_valid <= 1'b1;
                    end
                end
                PH_RESP: begin
                    if (rsp_ready) begin
                        phase <= PH_IDLE;
                    end
                end
                default: begin
                    if (res_valid) begin
                        phase     <= phase_nx;
                        job_valid <= (phase_nx != PH_RESP);
                    end
                end
            endcase
        end
    end

    // nack from any slot sticks until the response leaves
    always_ff @(posedge dri_clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q    <= cmd;
            nack_acc <= 1'b0;
            rdata_q  <= '0;
        end else if (res_valid) begin
            nack_acc <= nack_acc | res.nack;
            if (phase == PH_RDATA) begin
                rdata_q <= res.data;
            end
        end
    end

endmodule

`default_nettype wire

/* i2c_byte_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_engine
    import i2c_bus_pkg::*;
(
    input  logic      dri_clk,
    input  logic      rst_n,

    input  logic      job_valid,
    input  byte_job_t job,
    output logic      job_ready,

    output logic      res_valid,
    output byte_res_t res,

    output logic      scl,
    output logic      sda_oe,                            // high pulls sda low
    input  logic      sda_in
);

    seg_t             seg;
    seg_t             seg_nx;
    qtr_t             qtr;
    qtr_t             qtr_nx;
    logic [BIT_W-1:0] bit_cnt;
    logic [BIT_W-1:0] bit_nx;
    logic             accept;
    logic             done;
    logic             tx_low;
    logic             scl_d;
    logic             oe_d;
    logic [7:0]       shreg;
    logic             stop_q;
    logic             rd_q;
    logic             nack_q;

    assign job_ready = (seg == SEG_IDLE);
    assign accept    = job_valid && job_ready;
    assign done      = (qtr == Q_FALL) &&
                       ((seg == SEG_ACK && !stop_q) || seg == SEG_STOP);

    // bit to put out at the next setup quarter, read jobs keep sda released
    assign tx_low = accept ? (!job.rd && !job.data[7]) : (!rd_q && !shreg[7]);

    // ----------------------------------------------------------
    // segment and quarter counters
    // ----------------------------------------------------------
    always_comb begin
        seg_nx = seg;
        qtr_nx = qtr_t'(qtr + 1'b1);                     // wraps after Q_FALL
        bit_nx = bit_cnt;
        if (seg == SEG_IDLE) begin
            qtr_nx = Q_SETUP;
            bit_nx = '0;
            if (job_valid) begin
                seg_nx = job.start ? SEG_START : SEG_BITS;
            end
        end else if (qtr == Q_FALL) begin
            case (seg)
                SEG_START: seg_nx = SEG_BITS;
                SEG_BITS: begin
                    if (bit_cnt == BIT_W'(BITS_PER_BYTE - 1)) begin
                        seg_nx = SEG_ACK;
                    end else begin
                        bit_nx = bit_cnt + 1'b1;
                    end
                end
                SEG_ACK: seg_nx = stop_q ? SEG_STOP : SEG_IDLE;
                default: seg_nx = SEG_IDLE;
            endcase
        end
    end

    // bus levels for the quarter being entered, idle holds the last level
    always_comb begin
        scl_d = scl;
        oe_d  = sda_oe;
        if (seg_nx != SEG_IDLE) begin
            scl_d = (qtr_nx == Q_RISE) || (qtr_nx == Q_SAMPLE) ||
                    (qtr_nx == Q_FALL && seg_nx == SEG_STOP);
            case (seg_nx)
                SEG_START: begin
                    if (qtr_nx == Q_SETUP) begin
                        oe_d = 1'b0;                     // sda high before the edge
                    end else if (qtr_nx == Q_SAMPLE) begin
                        oe_d = 1'b1;                     // sda falls, scl high
                    end
                end
                SEG_BITS: begin
                    if (qtr_nx == Q_SETUP) begin
                        oe_d = tx_low;
                    end
                end
                SEG_ACK: begin
                    if (qtr_nx == Q_SETUP) begin
                        oe_d = 1'b0;                     // slave ack, or our nack
                    end
                end
                SEG_STOP: begin
                    if (qtr_nx == Q_SETUP) begin
                        oe_d = 1'b1;
                    end else if (qtr_nx == Q_SAMPLE) begin
                        oe_d = 1'b0;                     // sda rises, scl high
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            seg       <= SEG_IDLE;
            qtr       <= Q_SETUP;
            bit_cnt   <= '0;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            seg       <= seg_nx;
            qtr       <= qtr_nx;
            bit_cnt   <= bit_nx;
            scl       <= scl_d;
            sda_oe    <= oe_d;
            res_valid <= done;                           // one cycle pulse
        end
    end

    // ----------------------------------------------------------
    // shift register, msb first in both directions
    // ----------------------------------------------------------
    always_ff @(posedge dri_clk) begin
        if (accept) begin
            shreg  <= job.data;
            stop_q <= job.stop;
            rd_q   <= job.rd;
        end else if (seg == SEG_BITS && qtr == Q_SAMPLE) begin
            shreg <= {shreg[6:0], sda_in};
        end
        if (seg == SEG_ACK && qtr == Q_SAMPLE) begin
            nack_q <= sda_in && !rd_q;                   // own nack is not an error
        end
    end

    assign res = '{nack: nack_q, data: shreg};

endmodule

`default_nettype wire

/* i2c_master.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_master
    import i2c_bus_pkg::*, i2c_xact_pkg::*;
(
    input  logic     dri_clk,
    input  logic     rst_n,

    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  i2c_cmd_t cmd,

    output logic     rsp_valid,
    input  logic     rsp_ready,
    output i2c_rsp_t rsp,

    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    // command stage to sequencer
    i2c_cmd_t  seq_cmd;
    logic      seq_cmd_valid;
    logic      seq_cmd_ready;

    // sequencer to byte engine and back
    byte_job_t job;
    logic      job_valid;
    logic      job_ready;
    byte_res_t res;
    logic      res_valid;

    // sequencer to response stage
    i2c_rsp_t  seq_rsp;
    logic      seq_rsp_valid;
    logic      seq_rsp_ready;

    i2c_hold_stage #(.payload_t(i2c_cmd_t)) u_cmd_stage (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .in_valid  (cmd_valid),
        .in_data   (cmd),
        .in_ready  (cmd_ready),
        .out_valid (seq_cmd_valid),
        .out_data  (seq_cmd),
        .out_ready (seq_cmd_ready)
    );

    i2c_sequencer u_sequencer (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .cmd_valid (seq_cmd_valid),
        .cmd       (seq_cmd),
        .cmd_ready (seq_cmd_ready),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .res_valid (res_valid),
        .res       (res),
        .rsp_valid (seq_rsp_valid),
        .rsp       (seq_rsp),
        .rsp_ready (seq_rsp_ready)
    );

    i2c_byte_engine u_byte_engine (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .res_valid (res_valid),
        .res       (res),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

    i2c_hold_stage #(.payload_t(i2c_rsp_t)) u_rsp_stage (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .in_valid  (seq_rsp_valid),
        .in_data   (seq_rsp),
        .in_ready  (seq_rsp_ready),
        .out_valid (rsp_valid),
        .out_data  (rsp),
        .out_ready (rsp_ready)
    );

endmodule

`default_nettype wire

/* i2c_eeprom_model.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_eeprom_model (
    input  logic scl,
    input  logic sda_oe,                                 // master pulls sda low
    output logic sda,                                    // resolved line
    input  logic mode16,                                 // two word address bytes
    input  logic force_nack                              // refuse the data byte
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RX   = 2'd1;
    localparam logic [1:0] ST_TX   = 2'd2;

    logic [7:0]  mem [0:65535];
    logic        pull;
    logic [1:0]  state;
    logic [1:0]  byte_idx;                               // dev, hi, lo, data
    logic [3:0]  bit_cnt;
    logic [7:0]  shreg;
    logic [7:0]  txbyte;
    logic [15:0] ptr;
    logic        in_ack;
    logic        ack_ok;
    logic        go_tx;
    logic        scl_q;
    logic        sda_q;

    assign sda = !(sda_oe || pull);                      // pull-up otherwise

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'hff;                              // erased
        end
        pull     = 1'b0;
        state    = ST_IDLE;
        byte_idx = 2'd0;
        bit_cnt  = 4'd0;
        shreg    = 8'h00;
        txbyte   = 8'h00;
        ptr      = 16'h0000;
        in_ack   = 1'b0;
        ack_ok   = 1'b0;
        go_tx    = 1'b0;
        scl_q    = 1'b1;
        sda_q    = 1'b1;
    end

    always @(scl or sda) begin
        if (scl !== scl_q) begin
            if (scl) begin
                if (state == ST_RX && !in_ack && bit_cnt != 4'd8) begin
                    shreg   = {shreg[6:0], sda};
                    bit_cnt = bit_cnt + 4'd1;
                end else if (state == ST_TX) begin
                    if (bit_cnt == 4'd8) begin
                        state = ST_IDLE;                 // master ack slot, last byte
                    end else begin
                        bit_cnt = bit_cnt + 4'd1;
                    end
                end
            end else if (state == ST_RX) begin
                if (in_ack) begin
                    pull    = 1'b0;
                    in_ack  = 1'b0;
                    bit_cnt = 4'd0;
                    if (!ack_ok) begin
                        state = ST_IDLE;
                    end else if (go_tx) begin
                        state  = ST_TX;
                        txbyte = mem[ptr];
                        pull   = !txbyte[7];
                    end
                end else if (bit_cnt == 4'd8) begin
                    ack_ok = 1'b1;
                    go_tx  = 1'b0;
                    case (byte_idx)
                        2'd0: begin
                            ack_ok   = (shreg[7:1] == 7'h52);
                            go_tx    = shreg[0];
                            byte_idx = mode16 ? 2'd1 : 2'd2;
                        end
                        2'd1: begin
                            ptr[15:8] = shreg;
                            byte_idx  = 2'd2;
                        end
                        2'd2: begin
                            ptr[7:0] = shreg;
                            if (!mode16) begin
                                ptr[15:8] = 8'h00;
                            end
                            byte_idx = 2'd3;
                        end
                        default: begin
                            ack_ok = !force_nack;
                            if (ack_ok) begin
                                mem[ptr] = shreg;
                                ptr      = ptr + 16'd1;
                            end
                        end
                    endcase
                    in_ack = 1'b1;
                    pull   = ack_ok;
                end
            end else if (state == ST_TX) begin
                pull = (bit_cnt < 4'd8) ? !txbyte[3'd7 - bit_cnt[2:0]] : 1'b0;
            end
        end else if (scl && sda !== sda_q) begin
            if (!sda) begin                              // start or repeated start
                state    = ST_RX;
                byte_idx = 2'd0;
                bit_cnt  = 4'd0;
                in_ack   = 1'b0;
            end else begin                               // stop
                state = ST_IDLE;
            end
            pull = 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

/* i2c_master_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_master_chk
    import i2c_xact_pkg::*;
(
    input logic     dri_clk,
    input logic     rst_n,
    input logic     cmd_ready,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input i2c_rsp_t rsp,
    input logic     scl,
    input logic     sda_oe
);

    // outputs while reset is held
    reset_state: assert property (@(posedge dri_clk)
        !rst_n |-> scl && !sda_oe && !rsp_valid && cmd_ready)
        else $error("outputs left their reset values during reset");

    // held response waits unchanged
    rsp_stable: assert property (@(posedge dri_clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while stalled");

    // sda never moves on an scl edge, so a move with scl high is a start or stop
    sda_vs_scl: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (sda_oe != $past(sda_oe)) |-> (scl == $past(scl)))
        else $error("sda moved together with scl");

endmodule

bind i2c_master i2c_master_chk u_chk (
    .dri_clk   (dri_clk),
    .rst_n     (rst_n),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .scl       (scl),
    .sda_oe    (sda_oe)
);

`default_nettype wire

/* tb_i2c_master.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_master import i2c_xact_pkg::*; ();

    localparam int N_OPS      = 46;
    localparam int CYC_PER_OP = 250;                     // 16-bit read is about 200
    localparam int STALL_CYC  = CYC_PER_OP;              // longer than the read still on the bus

    logic       dri_clk;
    logic       rst_n;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       rsp_valid;
    logic       rsp_ready;
    logic       scl;
    logic       sda_oe;
    logic       sda;
    logic       mode16;
    logic       force_nack;
    i2c_cmd_t   cmd;
    i2c_rsp_t   rsp;
    logic [7:0] ref_mem [0:65535];
    i2c_rsp_t   exp_q [$];
    int         errors;
    int         checks;

    i2c_master uut (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    i2c_eeprom_model u_eeprom (
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda        (sda),
        .mode16     (mode16),
        .force_nack (force_nack)
    );

    initial begin
        dri_clk = 1'b0;
        forever #50 dri_clk = ~dri_clk;
    end

    initial begin
        repeat ((N_OPS * CYC_PER_OP + STALL_CYC) * 2) @(posedge dri_clk);
        $display("timeout, transactions did not complete");
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [15:0] eff_addr(input logic a16, input logic [15:0] addr);
        return a16 ? addr : {8'h00, addr[7:0]};           // 8-bit mode sees page 0
    endfunction

    // hand one command over and note the response it should give
    task automatic issue(input logic rd, input logic a16, input logic [15:0] addr,
                         input logic [7:0] wdata, input logic nack_exp);
        i2c_rsp_t e;
        @(negedge dri_clk);
        mode16    = a16;
        cmd       = '{rd: rd, addr16: a16, addr: addr, wdata: wdata};
        cmd_valid = 1'b1;
        while (!cmd_ready) @(negedge dri_clk);
        @(negedge dri_clk);
        cmd_valid = 1'b0;
        e.nack  = rd ? 1'b0 : nack_exp;
        e.rdata = rd ? ref_mem[eff_addr(a16, addr)] : 8'h00;
        if (!rd && !nack_exp) begin
            ref_mem[eff_addr(a16, addr)] = wdata;
        end
        exp_q.push_back(e);
    endtask

    task automatic collect();
        i2c_rsp_t got;
        i2c_rsp_t exp;
        @(negedge dri_clk);
        rsp_ready = 1'b1;
        while (!rsp_valid) @(negedge dri_clk);
        got = rsp;
        exp = exp_q.pop_front();
        @(negedge dri_clk);
        rsp_ready = 1'b0;
        check("rsp.nack", 16'(got.nack), 16'(exp.nack));
        check("rsp.rdata", 16'(got.rdata), 16'(exp.rdata));
    endtask

    task automatic xact(input logic rd, input logic a16, input logic [15:0] addr,
                        input logic [7:0] wdata, input logic nack_exp);
        issue(rd, a16, addr, wdata, nack_exp);
        collect();
    endtask

    // ----------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------
    task automatic addr8_write_read();
        int e0;
        e0 = errors;
        xact(1'b0, 1'b0, 16'h0010, 8'h3c, 1'b0);
        xact(1'b0, 1'b0, 16'h00a7, 8'h81, 1'b0);
        xact(1'b0, 1'b0, 16'h00f1, 8'h5e, 1'b0);
        xact(1'b1, 1'b0, 16'h0010, 8'h00, 1'b0);
        xact(1'b1, 1'b0, 16'h00a7, 8'h00, 1'b0);
        xact(1'b1, 1'b0, 16'h00f1, 8'h00, 1'b0);
        $display("test addr8 done, %0d errors", errors - e0);
    endtask

    task automatic addr16_high_byte();
        int e0;
        e0 = errors;
        xact(1'b0, 1'b1, 16'h1234, 8'ha5, 1'b0);
        xact(1'b0, 1'b1, 16'h5634, 8'h5a, 1'b0);         // same low byte
        xact(1'b1, 1'b1, 16'h1234, 8'h00, 1'b0);
        xact(1'b1, 1'b1, 16'h5634, 8'h00, 1'b0);
        $display("test addr16 done, %0d errors", errors - e0);
    endtask

    task automatic nack_then_rewrite();
        int e0;
        e0 = errors;
        force_nack = 1'b1;
        xact(1'b0, 1'b1, 16'h0777, 8'h11, 1'b1);
        check("scl", 16'(scl), 16'h0001);                // bus back to idle
        check("sda_oe", 16'(sda_oe), 16'h0000);
        force_nack = 1'b0;
        xact(1'b0, 1'b1, 16'h0777, 8'h22, 1'b0);
        xact(1'b1, 1'b1, 16'h0777, 8'h00, 1'b0);
        $display("test nack done, %0d errors", errors - e0);
    endtask

    task automatic backpressure_order();
        int e0;
        e0 = errors;
        issue(1'b0, 1'b0, 16'h0040, 8'h77, 1'b0);
        issue(1'b1, 1'b0, 16'h0040, 8'h00, 1'b0);
        issue(1'b1, 1'b0, 16'h0010, 8'h00, 1'b0);
        check("cmd_ready", 16'(cmd_ready), 16'h0000);    // third command held
        repeat (STALL_CYC) @(negedge dri_clk);
        check("cmd_ready", 16'(cmd_ready), 16'h0000);    // still full with the bus quiet
        check("rsp_valid", 16'(rsp_valid), 16'h0001);
        check("scl", 16'(scl), 16'h0001);
        check("sda_oe", 16'(sda_oe), 16'h0000);
        repeat (3) collect();
        $display("test backpressure done, %0d errors", errors - e0);
    endtask

    task automatic random_mix();
        int          e0;
        logic        rd;
        logic        a16;
        logic [15:0] addr;
        e0 = errors;
        repeat (30) begin
            rd   = 1'($urandom);
            a16  = 1'($urandom);
            addr = {8'($urandom % 3), 8'h60 + 8'($urandom % 6)};
            xact(rd, a16, addr, 8'($urandom), 1'b0);
        end
        $display("test random done, %0d errors", errors - e0);
    endtask

    initial begin
        void'($urandom(32'h82b9_9f32));
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rsp_ready  = 1'b0;
        mode16     = 1'b0;
        force_nack = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = 8'hff;
        end
        #10 rst_n = 1'b0;
        repeat (16) @(posedge dri_clk);
        @(negedge dri_clk);
        rst_n = 1'b1;
        addr8_write_read();
        addr16_high_byte();
        nack_then_rewrite();
        backpressure_order();
        random_mix();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
i2c_bus_pkg.sv
i2c_xact_pkg.sv
i2c_hold_stage.sv
i2c_sequencer.sv
i2c_byte_engine.sv
i2c_master.sv
i2c_eeprom_model.sv
i2c_master_chk.sv
tb_i2c_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
